// File: hw/ic_geom_pkg.sv
// Instruction cache geometry: way and subbank counts, array depths, address fields
package ic_geom_pkg;

   ////////////////////
   // Geometry
   ////////////////////

   localparam int NUM_WAYS        = 4;     // Ways per set
   localparam int NUM_SUBBANKS    = 4;     // 34-bit subbanks per 16-byte row
   localparam int ICACHE_TAG_HIGH = 12;    // Lowest tag address bit
   localparam int ICACHE_TAG_LOW  = 6;     // Lowest tag index bit (64-byte lines)
   localparam int TAG_DEPTH       = 64;    // Tag sets
   localparam int DATA_DEPTH      = 256;   // Data rows

   ////////////////////
   // Address fields
   ////////////////////

   typedef logic [NUM_WAYS-1:0] way_vec_t;           // One bit per way

   typedef logic [31:3] rw_addr_t;                   // Fetch or fill address, 8-byte beats

   typedef logic [ICACHE_TAG_HIGH-1:2] debug_addr_t; // Debug word address

   typedef logic [$clog2(TAG_DEPTH)-1:0] tag_index_t;

   typedef logic [$clog2(DATA_DEPTH)-1:0] data_index_t;

endpackage

// File: hw/ic_word_pkg.sv
// Instruction cache stored word formats: tag entries, subbank words, fill beats, read rows
package ic_word_pkg;

   ////////////////////
   // Tag array words
   ////////////////////

   typedef logic [31-ic_geom_pkg::ICACHE_TAG_HIGH:0] tag_t;   // Address bits 31:12

   typedef struct packed {
      logic parity;                     // Even parity over the tag
      tag_t tag;
   } tag_entry_t;

   ////////////////////
   // Data array words
   ////////////////////

   // A 16-bit instruction parcel with its parity bit above it
   typedef struct packed {
      logic        parity;
      logic [15:0] data;
   } parcel_t;

   typedef struct packed {
      parcel_t hi;
      parcel_t lo;
   } subbank_word_t;                    // 34 bits as supplied by the fill source

   typedef struct packed {
      subbank_word_t odd;               // Subbank 1 or 3
      subbank_word_t even;              // Subbank 0 or 2
   } fill_data_t;

   typedef logic [$bits(subbank_word_t)-1:0] debug_wr_data_t;

   typedef subbank_word_t [ic_geom_pkg::NUM_SUBBANKS-1:0] row_data_t;   // Subbank 0 lowest

endpackage

// File: hw/ic_way_ram.sv
// One-way synchronous single-port RAM with a registered read, entry type set per instance
`timescale 1ns/1ns

module ic_way_ram #(
   parameter type entry_t = logic,
   parameter int  DEPTH   = 64
) (
   input  logic                     clk,
   input  logic                     we,
   input  logic [$clog2(DEPTH)-1:0] addr,
   input  entry_t                   d,
   output entry_t                   q
);

   entry_t mem [DEPTH];

   // Read every cycle; a write returns the old entry
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= d;
      end
      q <= mem[addr];
   end

endmodule

// File: hw/ic_tag_array.sv
// Instruction cache tag array: per-way tag storage, parity generate and check, hit compare
`timescale 1ns/1ns

module ic_tag_array (
   input  logic                        clk,
   input  logic                        reset,
   input  ic_geom_pkg::rw_addr_t       ic_rw_addr,
   input  ic_geom_pkg::way_vec_t       ic_wr_en,            // Fill way
   input  logic                        ic_rd_en,            // Lookup
   input  ic_geom_pkg::debug_addr_t    ic_debug_addr,
   input  logic                        ic_debug_rd_en,
   input  logic                        ic_debug_wr_en,
   input  logic                        ic_debug_tag_array,  // Debug targets the tags
   input  ic_geom_pkg::way_vec_t       ic_debug_way,
   input  ic_word_pkg::debug_wr_data_t ic_debug_wr_data,
   input  ic_geom_pkg::way_vec_t       ic_tag_valid,        // Valid bits held outside
   output ic_geom_pkg::way_vec_t       ic_rd_hit,
   output logic                        ic_tag_perr,
   output ic_word_pkg::tag_entry_t     ictag_debug_rd_data
);

   import ic_geom_pkg::*;
   import ic_word_pkg::*;

   tag_t                      fill_tag;
   tag_t                      ic_rw_addr_ff;       // Tag of the last lookup
   tag_entry_t                tag_wr_entry;
   tag_index_t                tag_index;
   way_vec_t                  tag_wren;
   way_vec_t                  debug_rd_way;
   way_vec_t                  debug_wr_way;
   way_vec_t                  debug_rd_way_ff;
   way_vec_t                  way_perr;
   tag_entry_t [NUM_WAYS-1:0] tag_rd_entry;
   logic [$bits(tag_entry_t)-1:0] debug_rd_mux;

   ////////////////////
   // Write side
   ////////////////////

   assign fill_tag     = ic_rw_addr[31:ICACHE_TAG_HIGH];
   assign debug_rd_way = {NUM_WAYS{ic_debug_rd_en & ic_debug_tag_array}} & ic_debug_way;
   assign debug_wr_way = {NUM_WAYS{ic_debug_wr_en & ic_debug_tag_array}} & ic_debug_way;

   // Tag goes in with the last beat of the line
   assign tag_wren = (ic_wr_en & {NUM_WAYS{ic_rw_addr[5:3] == 3'b111}}) | debug_wr_way;

   always_comb begin
      if (ic_debug_wr_en && ic_debug_tag_array) begin
         tag_wr_entry.parity = ic_debug_wr_data[32];                 // Debug parity as given
         tag_wr_entry.tag    = ic_debug_wr_data[31:ICACHE_TAG_HIGH];
      end else begin
         tag_wr_entry.parity = ^fill_tag;                             // Even parity
         tag_wr_entry.tag    = fill_tag;
      end
   end

   // Debug address owns the index whenever a debug access is up
   assign tag_index = (ic_debug_rd_en | ic_debug_wr_en) ?
                      ic_debug_addr[ICACHE_TAG_HIGH-1:ICACHE_TAG_LOW] :
                      ic_rw_addr[ICACHE_TAG_HIGH-1:ICACHE_TAG_LOW];

   ////////////////////
   // Registered stage
   ////////////////////

   always_ff @(posedge clk) begin
      if (ic_rd_en) begin
         ic_rw_addr_ff <= fill_tag;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         debug_rd_way_ff <= '0;
      end else begin
         debug_rd_way_ff <= debug_rd_way;
      end
   end

   ////////////////////
   // Ways
   ////////////////////

   for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
      ic_way_ram #(
         .entry_t (tag_entry_t),
         .DEPTH   (TAG_DEPTH)
      ) u_tag_ram (
         .clk  (clk),
         .we   (tag_wren[i]),
         .addr (tag_index),
         .d    (tag_wr_entry),
         .q    (tag_rd_entry[i])
      );

      // Odd number of ones across parity and tag is an error
      assign way_perr[i]  = ^{tag_rd_entry[i].parity, tag_rd_entry[i].tag};
      assign ic_rd_hit[i] = (tag_rd_entry[i].tag == ic_rw_addr_ff) & ic_tag_valid[i];
   end

   assign ic_tag_perr = |(way_perr & ic_tag_valid);   // Invalid ways hold junk

   // Raw entry of the debug way, zero otherwise
   always_comb begin
      debug_rd_mux = '0;
      for (int i = 0; i < NUM_WAYS; i++) begin
         debug_rd_mux = debug_rd_mux |
                        ({$bits(tag_entry_t){debug_rd_way_ff[i]}} & tag_rd_entry[i]);
      end
   end

   assign ictag_debug_rd_data = tag_entry_t'(debug_rd_mux);

endmodule

// File: hw/ic_data_array.sv
// Instruction cache data array: subbank storage per way, fill and debug steering, row select
`timescale 1ns/1ns

module ic_data_array (
   input  logic                        clk,
   input  logic                        reset,
   input  ic_geom_pkg::rw_addr_t       ic_rw_addr,
   input  ic_geom_pkg::way_vec_t       ic_wr_en,            // Fill way
   input  logic                        ic_rd_en,            // Lookup
   input  ic_geom_pkg::debug_addr_t    ic_debug_addr,
   input  logic                        ic_debug_rd_en,
   input  logic                        ic_debug_wr_en,
   input  logic                        ic_debug_tag_array,
   input  ic_geom_pkg::way_vec_t       ic_debug_way,
   input  ic_word_pkg::fill_data_t     ic_wr_data,
   input  ic_word_pkg::debug_wr_data_t ic_debug_wr_data,
   input  ic_geom_pkg::way_vec_t       ic_rd_hit,           // From the tag compare
   output ic_word_pkg::row_data_t      ic_rd_data
);

   import ic_geom_pkg::*;
   import ic_word_pkg::*;

   way_vec_t                         debug_rd_way;
   way_vec_t                         debug_wr_way;
   way_vec_t                         debug_rd_way_ff;
   logic                             debug_rd_ff;
   logic                             rd_en_ff;
   way_vec_t                         row_sel;
   data_index_t                      data_index;
   way_vec_t [NUM_SUBBANKS-1:0]      sb_wren;          // Subbank, way
   subbank_word_t [NUM_SUBBANKS-1:0] sb_wr_data;
   row_data_t [NUM_WAYS-1:0]         way_row;

   assign debug_rd_way = {NUM_WAYS{ic_debug_rd_en & ~ic_debug_tag_array}} & ic_debug_way;
   assign debug_wr_way = {NUM_WAYS{ic_debug_wr_en & ~ic_debug_tag_array}} & ic_debug_way;

   assign data_index = (ic_debug_rd_en | ic_debug_wr_en) ?
                       ic_debug_addr[ICACHE_TAG_HIGH-1:4] :
                       ic_rw_addr[ICACHE_TAG_HIGH-1:4];

   ////////////////////
   // Subbanks
   ////////////////////

   for (genvar k = 0; k < NUM_SUBBANKS; k++) begin : g_sb
      localparam logic       UPPER_PAIR = (k >= NUM_SUBBANKS / 2);
      localparam logic [1:0] SB_SEL     = 2'(k);

      logic debug_sel;
      assign debug_sel = (ic_debug_addr[3:2] == SB_SEL);

      // Fill beat covers one pair, debug hits one subbank
      assign sb_wren[k] = (ic_wr_en & {NUM_WAYS{ic_rw_addr[3] == UPPER_PAIR}}) |
                          (debug_wr_way & {NUM_WAYS{debug_sel}});

      if (k % 2 == 0) begin : g_even
         assign sb_wr_data[k] = (debug_sel & ic_debug_wr_en) ?
                                subbank_word_t'(ic_debug_wr_data) : ic_wr_data.even;
      end else begin : g_odd
         assign sb_wr_data[k] = (debug_sel & ic_debug_wr_en) ?
                                subbank_word_t'(ic_debug_wr_data) : ic_wr_data.odd;
      end

      for (genvar i = 0; i < NUM_WAYS; i++) begin : g_way
         ic_way_ram #(
            .entry_t (subbank_word_t),
            .DEPTH   (DATA_DEPTH)
         ) u_data_ram (
            .clk  (clk),
            .we   (sb_wren[k][i]),
            .addr (data_index),
            .d    (sb_wr_data[k]),
            .q    (way_row[i][k])
         );
      end
   end

   ////////////////////
   // Read select
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         debug_rd_way_ff <= '0;
         debug_rd_ff     <= 1'b0;
         rd_en_ff        <= 1'b0;
      end else begin
         debug_rd_way_ff <= debug_rd_way;
         debug_rd_ff     <= ic_debug_rd_en;
         rd_en_ff        <= ic_rd_en;
      end
   end

   // Debug way overrides the hit for one cycle
   assign row_sel = debug_rd_ff ? debug_rd_way_ff : (ic_rd_hit & {NUM_WAYS{rd_en_ff}});

   always_comb begin
      ic_rd_data = '0;
      for (int i = 0; i < NUM_WAYS; i++) begin
         if (row_sel[i]) begin
            ic_rd_data = ic_rd_data | way_row[i];
         end
      end
   end

endmodule

// File: hw/ic_mem.sv
// Instruction cache memory top: tag array and data array sharing fill, lookup and debug ports
`timescale 1ns/1ns

module ic_mem (
   input  logic                        clk,
   input  logic                        reset,
   input  ic_geom_pkg::rw_addr_t       ic_rw_addr,          // Fetch or fill address
   input  ic_geom_pkg::way_vec_t       ic_wr_en,            // Fill way
   input  logic                        ic_rd_en,            // Lookup
   input  ic_word_pkg::fill_data_t     ic_wr_data,          // One 8-byte beat with parity
   input  ic_geom_pkg::debug_addr_t    ic_debug_addr,
   input  logic                        ic_debug_rd_en,
   input  logic                        ic_debug_wr_en,
   input  logic                        ic_debug_tag_array,
   input  ic_geom_pkg::way_vec_t       ic_debug_way,
   input  ic_word_pkg::debug_wr_data_t ic_debug_wr_data,
   input  ic_geom_pkg::way_vec_t       ic_tag_valid,
   output ic_word_pkg::row_data_t      ic_rd_data,
   output ic_word_pkg::tag_entry_t     ictag_debug_rd_data,
   output ic_geom_pkg::way_vec_t       ic_rd_hit,
   output logic                        ic_tag_perr
);

   ic_tag_array u_tag_array (
      .clk                 (clk),
      .reset               (reset),
      .ic_rw_addr          (ic_rw_addr),
      .ic_wr_en            (ic_wr_en),
      .ic_rd_en            (ic_rd_en),
      .ic_debug_addr       (ic_debug_addr),
      .ic_debug_rd_en      (ic_debug_rd_en),
      .ic_debug_wr_en      (ic_debug_wr_en),
      .ic_debug_tag_array  (ic_debug_tag_array),
      .ic_debug_way        (ic_debug_way),
      .ic_debug_wr_data    (ic_debug_wr_data),
      .ic_tag_valid        (ic_tag_valid),
      .ic_rd_hit           (ic_rd_hit),
      .ic_tag_perr         (ic_tag_perr),
      .ictag_debug_rd_data (ictag_debug_rd_data)
   );

   // Hit from the tags picks the data way
   ic_data_array u_data_array (
      .clk                (clk),
      .reset              (reset),
      .ic_rw_addr         (ic_rw_addr),
      .ic_wr_en           (ic_wr_en),
      .ic_rd_en           (ic_rd_en),
      .ic_debug_addr      (ic_debug_addr),
      .ic_debug_rd_en     (ic_debug_rd_en),
      .ic_debug_wr_en     (ic_debug_wr_en),
      .ic_debug_tag_array (ic_debug_tag_array),
      .ic_debug_way       (ic_debug_way),
      .ic_wr_data         (ic_wr_data),
      .ic_debug_wr_data   (ic_debug_wr_data),
      .ic_rd_hit          (ic_rd_hit),
      .ic_rd_data         (ic_rd_data)
   );

endmodule

// File: bench/ic_mem_assertions.sv
// Tag array checks: hit and parity error only on valid ways, debug enables, debug read data
`timescale 1ns/1ns

module ic_mem_assertions (
   input logic                    clk,
   input logic                    reset,
   input logic                    ic_debug_rd_en,
   input logic                    ic_debug_wr_en,
   input logic                    ic_debug_tag_array,
   input ic_geom_pkg::way_vec_t   ic_tag_valid,
   input ic_geom_pkg::way_vec_t   ic_rd_hit,
   input logic                    ic_tag_perr,
   input ic_word_pkg::tag_entry_t ictag_debug_rd_data
);

   int fail_count = 0;   // Failed assertions so far

   hit_needs_valid: assert property (@(posedge clk) disable iff (reset)
      (ic_rd_hit & ~ic_tag_valid) == '0)
      else begin
         fail_count++;
         $error("hit reported on a way that is not valid");
      end

   perr_needs_valid: assert property (@(posedge clk) disable iff (reset)
      ic_tag_perr |-> (ic_tag_valid != '0))
      else begin
         fail_count++;
         $error("tag parity error with no valid way");
      end

   debug_rd_wr_apart: assert property (@(posedge clk) disable iff (reset)
      !(ic_debug_rd_en && ic_debug_wr_en))
      else begin
         fail_count++;
         $error("debug read and debug write enabled together");
      end

   debug_data_idle_zero: assert property (@(posedge clk) disable iff (reset)
      !(ic_debug_rd_en && ic_debug_tag_array) |=> (ictag_debug_rd_data == '0))
      else begin
         fail_count++;
         $error("debug tag read data not zero without a debug tag read");
      end

endmodule

bind ic_tag_array ic_mem_assertions u_assertions (
   .clk                 (clk),
   .reset               (reset),
   .ic_debug_rd_en      (ic_debug_rd_en),
   .ic_debug_wr_en      (ic_debug_wr_en),
   .ic_debug_tag_array  (ic_debug_tag_array),
   .ic_tag_valid        (ic_tag_valid),
   .ic_rd_hit           (ic_rd_hit),
   .ic_tag_perr         (ic_tag_perr),
   .ictag_debug_rd_data (ictag_debug_rd_data)
);

// File: bench/ic_mem_tb.sv
// Testbench for the instruction cache memory: fill, lookup, miss, tag parity and debug access
`timescale 1ns/1ns

module ic_mem_tb;

   import ic_geom_pkg::*;
   import ic_word_pkg::*;

   localparam int CLK_PERIOD   = 4;
   localparam int SEED         = 52843;
   localparam int RESET_CYCLES = 2;
   localparam int FILL_WAY     = 2;
   localparam int PARITY_WAY   = 1;
   // Reset plus fill_hit, miss, way_select, tag_parity and debug accesses
   localparam int ACCESS_COUNT = RESET_CYCLES + 12 + 2 + 24 + 3 + 4;
   localparam int TIMEOUT_NS   = ACCESS_COUNT * CLK_PERIOD * 4;

   logic           clk;
   logic           reset;
   rw_addr_t       ic_rw_addr;
   way_vec_t       ic_wr_en;
   logic           ic_rd_en;
   fill_data_t     ic_wr_data;
   debug_addr_t    ic_debug_addr;
   logic           ic_debug_rd_en;
   logic           ic_debug_wr_en;
   logic           ic_debug_tag_array;
   way_vec_t       ic_debug_way;
   debug_wr_data_t ic_debug_wr_data;
   way_vec_t       ic_tag_valid;
   row_data_t      ic_rd_data;
   tag_entry_t     ictag_debug_rd_data;
   way_vec_t       ic_rd_hit;
   logic           ic_tag_perr;

   fill_data_t line_beats [NUM_WAYS][8];   // Last line filled into each way
   tag_t       tag_a, tag_b, tag_c, tag_d;
   tag_index_t set_a, set_b, set_d;
   tag_entry_t bad_entry;

   ic_mem u_ic_mem (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
      $display("*** FAILED ***");
      $fatal(1, "watchdog expired");
   end

   ////////////////////
   // Helpers
   ////////////////////

   function automatic way_vec_t way_bit(input int way);
      return way_vec_t'(1) << way;
   endfunction

   function automatic rw_addr_t line_addr(input tag_t tag, input tag_index_t set,
                                          input logic [2:0] beat);
      return {tag, set, beat};
   endfunction

   // Parity bit makes the count of ones even
   function automatic tag_entry_t parity_entry(input tag_t tag);
      tag_entry_t e;
      e.tag    = tag;
      e.parity = ($countones(tag) % 2) != 0;
      return e;
   endfunction

   // Beat with address bit 3 low lands in subbanks 0 and 1
   function automatic row_data_t expected_row(input int way, input int row);
      row_data_t r;
      r[0] = line_beats[way][2*row].even;
      r[1] = line_beats[way][2*row].odd;
      r[2] = line_beats[way][2*row+1].even;
      r[3] = line_beats[way][2*row+1].odd;
      return r;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic idle_inputs();
      ic_rw_addr         = '0;
      ic_wr_en           = '0;
      ic_rd_en           = 1'b0;
      ic_wr_data         = '0;
      ic_debug_addr      = '0;
      ic_debug_rd_en     = 1'b0;
      ic_debug_wr_en     = 1'b0;
      ic_debug_tag_array = 1'b0;
      ic_debug_way       = '0;
      ic_debug_wr_data   = '0;
      ic_tag_valid       = '0;
   endtask

   task automatic fill_line(input int way, input tag_t tag, input tag_index_t set);
      logic [95:0] word;
      for (int b = 0; b < 8; b++) begin
         word = {$urandom(), $urandom(), $urandom()};
         line_beats[way][b] = word[67:0];
         ic_wr_en   = way_bit(way);
         ic_rw_addr = line_addr(tag, set, 3'(b));
         ic_wr_data = line_beats[way][b];
         next_cycle();
      end
      ic_wr_en = '0;
   endtask

   // Returns mid-cycle with the lookup result on the outputs
   task automatic lookup(input rw_addr_t addr, input way_vec_t valid);
      ic_rd_en     = 1'b1;
      ic_rw_addr   = addr;
      ic_tag_valid = valid;
      next_cycle();
      ic_rd_en = 1'b0;
      @(negedge clk);
   endtask

   task automatic end_read();
      next_cycle();
      ic_tag_valid = '0;
   endtask

   task automatic debug_write(input logic tag_array, input int way, input debug_addr_t addr,
                              input debug_wr_data_t data);
      ic_debug_wr_en     = 1'b1;
      ic_debug_tag_array = tag_array;
      ic_debug_way       = way_bit(way);
      ic_debug_addr      = addr;
      ic_debug_wr_data   = data;
      next_cycle();
      ic_debug_wr_en = 1'b0;
   endtask

   task automatic debug_read(input logic tag_array, input int way, input debug_addr_t addr);
      ic_debug_rd_en     = 1'b1;
      ic_debug_tag_array = tag_array;
      ic_debug_way       = way_bit(way);
      ic_debug_addr      = addr;
      next_cycle();
      ic_debug_rd_en = 1'b0;
      @(negedge clk);
   endtask

   ////////////////////
   // Compare tasks
   ////////////////////

   task automatic check_way_vec(input string test_name, input way_vec_t expected,
                                input way_vec_t actual);
      if (actual !== expected) begin
         $display("error: %s expected %h actual %h", test_name, expected, actual);
         $display("*** FAILED ***");
         $fatal(1, "way vector mismatch in %s", test_name);
      end
   endtask

   task automatic check_row(input string test_name, input row_data_t expected,
                            input row_data_t actual);
      if (actual !== expected) begin
         $display("error: %s expected %h actual %h", test_name, expected, actual);
         $display("*** FAILED ***");
         $fatal(1, "row mismatch in %s", test_name);
      end
   endtask

   task automatic check_tag_entry(input string test_name, input tag_entry_t expected,
                                  input tag_entry_t actual);
      if (actual !== expected) begin
         $display("error: %s expected %h actual %h", test_name, expected, actual);
         $display("*** FAILED ***");
         $fatal(1, "tag entry mismatch in %s", test_name);
      end
   endtask

   task automatic check_bit(input string test_name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("error: %s expected %b actual %b", test_name, expected, actual);
         $display("*** FAILED ***");
         $fatal(1, "bit mismatch in %s", test_name);
      end
   endtask

   ////////////////////
   // Tests
   ////////////////////

   task automatic test_fill_hit();
      fill_line(FILL_WAY, tag_a, set_a);
      for (int r = 0; r < 4; r++) begin
         lookup(line_addr(tag_a, set_a, {2'(r), 1'b0}), way_bit(FILL_WAY));
         check_way_vec("fill_hit", way_bit(FILL_WAY), ic_rd_hit);
         check_row("fill_hit", expected_row(FILL_WAY, r), ic_rd_data);
         check_bit("fill_hit", 1'b0, ic_tag_perr);
         end_read();
      end
   endtask

   task automatic test_miss();
      lookup(line_addr(tag_a ^ 20'h1, set_a, 3'd0), way_bit(FILL_WAY));   // Wrong tag
      check_way_vec("miss_tag", '0, ic_rd_hit);
      check_row("miss_tag", '0, ic_rd_data);
      end_read();
      lookup(line_addr(tag_a, set_a, 3'd0), '0);                           // Way not valid
      check_way_vec("miss_invalid", '0, ic_rd_hit);
      check_row("miss_invalid", '0, ic_rd_data);
      end_read();
   endtask

   task automatic test_way_select();
      fill_line(0, tag_b, set_b);
      fill_line(3, tag_c, set_b);
      for (int r = 0; r < 4; r++) begin
         lookup(line_addr(tag_b, set_b, {2'(r), 1'b0}), 4'b1001);
         check_way_vec("way_select", way_bit(0), ic_rd_hit);
         check_row("way_select", expected_row(0, r), ic_rd_data);
         end_read();
         lookup(line_addr(tag_c, set_b, {2'(r), 1'b0}), 4'b1001);
         check_way_vec("way_select", way_bit(3), ic_rd_hit);
         check_row("way_select", expected_row(3, r), ic_rd_data);
         end_read();
      end
   endtask

   task automatic test_tag_parity();
      debug_wr_data_t wr;
      debug_addr_t    addr;
      bad_entry.tag    = tag_d;
      bad_entry.parity = ($countones(tag_d) % 2) == 0;   // Opposite of even parity
      wr         = '0;
      wr[32]     = bad_entry.parity;
      wr[31:12]  = bad_entry.tag;
      addr       = '0;
      addr[11:6] = set_d;
      debug_write(1'b1, PARITY_WAY, addr, wr);
      lookup(line_addr(tag_d, set_d, 3'd0), way_bit(PARITY_WAY));
      check_way_vec("tag_parity", way_bit(PARITY_WAY), ic_rd_hit);
      check_bit("tag_parity", 1'b1, ic_tag_perr);
      end_read();
      lookup(line_addr(tag_d, set_d, 3'd0), '0);
      check_bit("tag_parity_invalid", 1'b0, ic_tag_perr);
      end_read();
   endtask

   task automatic test_debug();
      debug_addr_t    addr;
      debug_wr_data_t word;
      row_data_t      expected;
      logic [63:0]    rnd;
      addr       = '0;
      addr[11:6] = set_d;
      debug_read(1'b1, PARITY_WAY, addr);
      check_tag_entry("debug_tag_written", bad_entry, ictag_debug_rd_data);
      next_cycle();
      addr[11:6] = set_a;
      debug_read(1'b1, FILL_WAY, addr);
      check_tag_entry("debug_tag_filled", parity_entry(tag_a), ictag_debug_rd_data);
      next_cycle();
      rnd        = {$urandom(), $urandom()};
      word       = rnd[33:0];
      addr       = '0;
      addr[11:4] = {set_a, 2'd1};   // Row 1 of the filled line
      addr[3:2]  = 2'd2;
      debug_write(1'b0, FILL_WAY, addr, word);
      expected    = expected_row(FILL_WAY, 1);
      expected[2] = word;
      debug_read(1'b0, FILL_WAY, addr);
      check_row("debug_data", expected, ic_rd_data);
      next_cycle();
   endtask

   initial begin
      logic [31:0] rnd;
      void'($urandom(SEED));
      idle_inputs();
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;
      rnd   = $urandom();
      tag_a = rnd[19:0];
      set_a = rnd[25:20];
      set_b = set_a + 6'd1;
      set_d = set_a + 6'd2;
      rnd   = $urandom();
      tag_b = rnd[19:0];
      tag_c = tag_b ^ 20'h80001;
      rnd   = $urandom();
      tag_d = rnd[19:0];
      test_fill_hit();
      test_miss();
      test_way_select();
      test_tag_parity();
      test_debug();
      if (u_ic_mem.u_tag_array.u_assertions.fail_count != 0) begin
         $display("assertion failures: %0d", u_ic_mem.u_tag_array.u_assertions.fail_count);
         $display("*** FAILED ***");
         $fatal(1, "bound assertions failed");
      end else begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

// File: project.f
hw/ic_geom_pkg.sv
hw/ic_word_pkg.sv
hw/ic_way_ram.sv
hw/ic_tag_array.sv
hw/ic_data_array.sv
hw/ic_mem.sv
bench/ic_mem_assertions.sv
bench/ic_mem_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the instruction cache memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module ic_mem_tb -o ic_mem_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/ic_mem_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
   echo "simulation reported failure"
   exit 1
fi

if [ $sim_status -ne 0 ]; then
   echo "simulator exited with status $sim_status"
   exit 1
fi

echo "simulation finished without failure"
exit 0
